// File: icachePkg.sv
// Instruction cache geometry, FSM state codes
// and the fetch address union shared by the cache blocks

`default_nettype none

package icachePkg;

    // Cache geometry
    localparam int numSets    = 8;
    localparam int blockWords = 4;
    localparam int setBits    = $clog2(numSets);
    localparam int wordBits   = $clog2(blockWords);
    localparam int tagBits    = 32 - setBits - wordBits - 2;

    // Fetch buffer depth toward decode
    localparam int bufDepth = 4;

    // Controller FSM encodings
    localparam logic [1:0] stIdle    = 2'd0;
    localparam logic [1:0] stLookup  = 2'd1;
    localparam logic [1:0] stRefill  = 2'd2;
    localparam logic [1:0] stRespond = 2'd3;

    // Byte address seen as a bus word or as cache index fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tagBits-1:0]  tag;
            logic [setBits-1:0]  set;
            logic [wordBits-1:0] word;
            logic [1:0]          byteOff;
        } fields;
    } fetchAddrT;

endpackage

`default_nettype wire

// File: cacheWays.sv
// Two-way tag, valid and data storage with one LRU bit per set
// Refill writes one word per cycle and global invalidate

`timescale 1ns/1ps
`default_nettype none

module cacheWays import icachePkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [setBits-1:0]       setIdx,
    input  logic [wordBits-1:0]      wordIdx,
    input  logic [1:0]               wayWe,
    input  logic [tagBits-1:0]       fillTag,
    input  logic [31:0]              fillData,
    input  logic                     lruWe,
    input  logic                     lruWay,
    input  logic                     invalidate,
    output logic [1:0]               validOut,
    output logic [1:0][tagBits-1:0]  tagOut,
    output logic [1:0][31:0]         dataOut,
    output logic                     lruOut
);

    logic [tagBits-1:0] tagMem  [2][numSets];
    logic [31:0]        dataMem [2][numSets][blockWords];
    logic [numSets-1:0] validMem [2];

    // Each bit names the least recently used way of its set
    logic [numSets-1:0] lruMem;

    logic lastWord;

    assign lastWord = (wordIdx == wordBits'(blockWords - 1));

    // Refill storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayWe[w]) begin
                dataMem[w][setIdx][wordIdx] <= fillData;
                // Tag lands with the last word of the block
                if (lastWord) begin
                    tagMem[w][setIdx] <= fillTag;
                end
            end
        end
    end

    // Line becomes valid only once the whole block is in
    always_ff @(posedge clk) begin
        if (!rstN || invalidate) begin
            validMem[0] <= '0;
            validMem[1] <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wayWe[w] && lastWord) begin
                    validMem[w][setIdx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || invalidate) begin
            lruMem <= '0;
        end else if (lruWe) begin
            lruMem[setIdx] <= lruWay;
        end
    end

    // Combinational read of the presented set and word
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            validOut[w] = validMem[w][setIdx];
            tagOut[w]   = tagMem[w][setIdx];
            dataOut[w]  = dataMem[w][setIdx][wordIdx];
        end
    end

    assign lruOut = lruMem[setIdx];

    // Controller refills a single victim way at a time
    singleWayWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(wayWe[0] && wayWe[1]))
        else $error("both cache ways written in one cycle");

endmodule

`default_nettype wire

// File: cacheController.sv
// Cache controller FSM: lookup register, hit detection, LRU update
// and four-beat block refill over the memory bus

`timescale 1ns/1ps
`default_nettype none

module cacheController import icachePkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     reqValid,
    input  logic [31:0]              reqAddr,
    input  logic                     invalidate,
    input  logic [1:0]               validOut,
    input  logic [1:0][tagBits-1:0]  tagOut,
    input  logic [1:0][31:0]         dataOut,
    input  logic                     lruOut,
    input  logic                     busReady,
    input  logic [31:0]              busData,
    input  logic                     pushReady,
    output logic                     reqReady,
    output logic                     busReq,
    output logic [31:0]              busAddr,
    output logic [setBits-1:0]       setIdx,
    output logic [wordBits-1:0]      wordIdx,
    output logic [1:0]               wayWe,
    output logic [tagBits-1:0]       fillTag,
    output logic [31:0]              fillData,
    output logic                     lruWe,
    output logic                     lruWay,
    output logic                     clearAll,
    output logic                     pushValid,
    output logic [31:0]              pushData,
    output logic [31:0]              pushAddr
);

    logic [1:0]          state;
    logic [wordBits-1:0] wordCnt;
    logic                invPending;
    fetchAddrT           addrReg;
    fetchAddrT           busAddrU;
    logic                wayReg;
    logic [1:0]          hitVec;
    logic                hit;
    logic                selWay;
    logic                curWay;
    logic                lastBeat;

    // Tag compare against the registered request
    assign hitVec[0] = validOut[0] && (tagOut[0] == addrReg.fields.tag);
    assign hitVec[1] = validOut[1] && (tagOut[1] == addrReg.fields.tag);
    assign hit       = |hitVec;

    // Hit way, or the LRU victim on a miss
    assign selWay = hit ? hitVec[1] : lruOut;
    assign curWay = (state == stLookup) ? selWay : wayReg;

    assign lastBeat = (wordCnt == wordBits'(blockWords - 1));

    // Invalidate only acts while idle
    assign clearAll = (state == stIdle) && (invPending || invalidate);
    assign reqReady = (state == stIdle) && !invPending && !invalidate;

    // Way array addressing
    assign setIdx  = addrReg.fields.set;
    assign wordIdx = (state == stRefill) ? wordCnt : addrReg.fields.word;

    // Refill path
    always_comb begin
        busAddrU              = addrReg;
        busAddrU.fields.word  = wordCnt;
        busAddrU.fields.byteOff = 2'b00;
    end

    assign busReq   = (state == stRefill);
    assign busAddr  = busAddrU.raw;
    assign fillTag  = addrReg.fields.tag;
    assign fillData = busData;
    assign wayWe[0] = busReq && busReady && !wayReg;
    assign wayWe[1] = busReq && busReady && wayReg;

    // Used way becomes MRU, so the other one is the next victim
    assign lruWe  = (state == stLookup);
    assign lruWay = ~selWay;

    // Push toward the fetch buffer
    assign pushValid = ((state == stLookup) && hit) || (state == stRespond);
    assign pushData  = dataOut[curWay];
    assign pushAddr  = addrReg.raw;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= stIdle;
            wordCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (reqValid && reqReady) begin
                        state <= stLookup;
                    end
                end
                stLookup: begin
                    if (!hit) begin
                        state <= stRefill;
                    end else if (pushReady) begin
                        state <= stIdle;
                    end else begin
                        state <= stRespond;
                    end
                end
                stRefill: begin
                    if (busReady) begin
                        wordCnt <= wordCnt + 1'b1;
                        if (lastBeat) begin
                            state <= stRespond;
                        end
                    end
                end
                default: begin
                    // Word is re-read from the filled way until taken
                    if (pushReady) begin
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

    // Reset leaves a clear pending so the arrays start empty
    always_ff @(posedge clk) begin
        if (!rstN) begin
            invPending <= 1'b1;
        end else if (clearAll) begin
            invPending <= 1'b0;
        end else if (invalidate) begin
            invPending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            addrReg.raw <= reqAddr;
        end
        if (state == stLookup) begin
            wayReg <= selWay;
        end
    end

    busAddrHold: assert property (@(posedge clk) disable iff (!rstN)
        busReq && !busReady |=> busReq && $stable(busAddr))
        else $error("busAddr changed while waiting for busReady");

    // A block lives in one way only
    oneHitWay: assert property (@(posedge clk) disable iff (!rstN)
        (state == stLookup) |-> !(hitVec[0] && hitVec[1]))
        else $error("both cache ways hit the same address");

endmodule

`default_nettype wire

// File: fetchBuffer.sv
// Circular FIFO of fetched instructions and their addresses
// feeding the decode stage

`timescale 1ns/1ps
`default_nettype none

module fetchBuffer import icachePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        pushValid,
    input  logic [31:0] pushData,
    input  logic [31:0] pushAddr,
    input  logic        rspReady,
    output logic        pushReady,
    output logic        rspValid,
    output logic [31:0] rspData,
    output logic [31:0] rspAddr
);

    logic [31:0]                  dataMem [bufDepth];
    logic [31:0]                  addrMem [bufDepth];
    logic [$clog2(bufDepth)-1:0]  wrPtr;
    logic [$clog2(bufDepth)-1:0]  rdPtr;
    logic [$clog2(bufDepth):0]    count;
    logic                         doPush;
    logic                         doPop;

    assign rspValid = (count != 0);
    // A full buffer still takes a push when decode pops the same cycle
    assign pushReady = (count != bufDepth) || rspReady;

    assign doPush = pushValid && pushReady;
    assign doPop  = rspValid && rspReady;

    assign rspData = dataMem[rdPtr];
    assign rspAddr = addrMem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            dataMem[wrPtr] <= pushData;
            addrMem[wrPtr] <= pushAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + doPush - doPop;
        end
    end

    countBound: assert property (@(posedge clk) disable iff (!rstN)
        count <= bufDepth)
        else $error("fetch buffer count above depth");

endmodule

`default_nettype wire

// File: instrCache.sv
// Instruction cache top level
// Controller, way storage and fetch buffer

`timescale 1ns/1ps
`default_nettype none

module instrCache import icachePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        reqValid,
    output logic        reqReady,
    input  logic [31:0] reqAddr,
    output logic        rspValid,
    input  logic        rspReady,
    output logic [31:0] rspData,
    output logic [31:0] rspAddr,
    output logic        busReq,
    output logic [31:0] busAddr,
    input  logic        busReady,
    input  logic [31:0] busData,
    input  logic        invalidate
);

    // Controller to ways
    logic [setBits-1:0]       setIdx;
    logic [wordBits-1:0]      wordIdx;
    logic [1:0]               wayWe;
    logic [tagBits-1:0]       fillTag;
    logic [31:0]              fillData;
    logic                     lruWe;
    logic                     lruWay;
    logic                     clearAll;

    // Ways back to controller
    logic [1:0]               validOut;
    logic [1:0][tagBits-1:0]  tagOut;
    logic [1:0][31:0]         dataOut;
    logic                     lruOut;

    // Controller to fetch buffer
    logic                     pushValid;
    logic                     pushReady;
    logic [31:0]              pushData;
    logic [31:0]              pushAddr;

    cacheController ctrl (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .reqAddr   (reqAddr),
        .invalidate(invalidate),
        .validOut  (validOut),
        .tagOut    (tagOut),
        .dataOut   (dataOut),
        .lruOut    (lruOut),
        .busReady  (busReady),
        .busData   (busData),
        .pushReady (pushReady),
        .reqReady  (reqReady),
        .busReq    (busReq),
        .busAddr   (busAddr),
        .setIdx    (setIdx),
        .wordIdx   (wordIdx),
        .wayWe     (wayWe),
        .fillTag   (fillTag),
        .fillData  (fillData),
        .lruWe     (lruWe),
        .lruWay    (lruWay),
        .clearAll  (clearAll),
        .pushValid (pushValid),
        .pushData  (pushData),
        .pushAddr  (pushAddr)
    );

    cacheWays ways (
        .clk       (clk),
        .rstN      (rstN),
        .setIdx    (setIdx),
        .wordIdx   (wordIdx),
        .wayWe     (wayWe),
        .fillTag   (fillTag),
        .fillData  (fillData),
        .lruWe     (lruWe),
        .lruWay    (lruWay),
        .invalidate(clearAll),
        .validOut  (validOut),
        .tagOut    (tagOut),
        .dataOut   (dataOut),
        .lruOut    (lruOut)
    );

    fetchBuffer fbuf (
        .clk      (clk),
        .rstN     (rstN),
        .pushValid(pushValid),
        .pushData (pushData),
        .pushAddr (pushAddr),
        .rspReady (rspReady),
        .pushReady(pushReady),
        .rspValid (rspValid),
        .rspData  (rspData),
        .rspAddr  (rspAddr)
    );

endmodule

`default_nettype wire

// File: tbMemory.sv
// Testbench memory bus slave
// Serves refill words with wait states chosen by the testbench top

`timescale 1ns/1ps
`default_nettype none

module tbMemory (
    input  logic        clk,
    input  logic        rstN,
    input  logic        busReq,
    input  logic [31:0] busAddr,
    input  logic        stall,
    output logic        busReady,
    output logic [31:0] busData,
    output int          beatCount
);

    // Memory content is the address scrambled and rotated left by 3
    function automatic logic [31:0] wordAt(input logic [31:0] addr);
        logic [31:0] mixed;
        mixed = addr ^ 32'h5a5a0000;
        return {mixed[28:0], mixed[31:29]};
    endfunction

    initial begin
        logic holdOff;
        busReady  = 1'b0;
        busData   = '0;
        beatCount = 0;
        forever begin
            @(posedge clk);
            // Stall was set a cycle ago and is stable at the edge
            holdOff = stall;
            #1;
            if (!rstN || !busReq) begin
                busReady = 1'b0;
            end else begin
                busReady = !holdOff;
            end
            busData = wordAt(busAddr);
            @(negedge clk);
            if (rstN && busReq && busReady) begin
                beatCount++;
            end
        end
    end

endmodule

`default_nettype wire

// File: icacheTb.sv
// Instruction cache testbench top
// Random requests from an LFSR, 2-way LRU reference model, response and refill checks

`timescale 1ns/1ps
`default_nettype none

module icacheTb import icachePkg::*; ();

    localparam int          numRequests    = 300;
    localparam int          watchdogCycles = numRequests * 400 + 200;
    localparam logic [31:0] addrBase       = 32'h0004_2000;

    logic        clk = 1'b0;
    logic        rstN;
    logic        reqValid;
    logic        reqReady;
    logic [31:0] reqAddr;
    logic        rspValid;
    logic        rspReady;
    logic [31:0] rspData;
    logic [31:0] rspAddr;
    logic        busReq;
    logic [31:0] busAddr;
    logic        busReady;
    logic [31:0] busData;
    logic        invalidate;
    logic        memStall;
    int          beatCount;

    logic [31:0] lfsrState = 32'hd3deee84;

    // Reference model with one LRU bit per set naming the next victim
    logic [tagBits-1:0] modelTag   [numSets][2];
    logic               modelValid [numSets][2];
    logic               modelLru   [numSets];

    logic [31:0] rspQueue[$];
    logic [31:0] refillQueue[$];

    logic        reqFire = 1'b0;
    logic        rspHeld = 1'b0;
    logic [31:0] heldAddr;
    int          hitStage = 0;
    logic [31:0] hitAddr;
    int          beatIdx = 0;
    int          issued = 0;
    int          errorCount = 0;
    int          hitCount = 0;
    int          missCount = 0;
    int          invalidateCount = 0;
    int          hitTimingCount = 0;

    always #10 clk = ~clk;

    instrCache DUT (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .reqAddr   (reqAddr),
        .rspValid  (rspValid),
        .rspReady  (rspReady),
        .rspData   (rspData),
        .rspAddr   (rspAddr),
        .busReq    (busReq),
        .busAddr   (busAddr),
        .busReady  (busReady),
        .busData   (busData),
        .invalidate(invalidate)
    );

    tbMemory mem (
        .clk      (clk),
        .rstN     (rstN),
        .busReq   (busReq),
        .busAddr  (busAddr),
        .stall    (memStall),
        .busReady (busReady),
        .busData  (busData),
        .beatCount(beatCount)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] expectedWord(input logic [31:0] addr);
        logic [31:0] mixed;
        mixed = addr ^ 32'h5a5a0000;
        return {mixed[28:0], mixed[31:29]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH %s: got %08h expected %08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic reportError(input string what);
        errorCount++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic clearModel();
        for (int s = 0; s < numSets; s++) begin
            modelValid[s][0] = 1'b0;
            modelValid[s][1] = 1'b0;
            modelLru[s]      = 1'b0;
        end
    endtask

    task automatic accessModel(input logic [31:0] addr, output logic hit);
        fetchAddrT a;
        int        setNum;
        int        way;
        a.raw  = addr;
        setNum = int'(a.fields.set);
        hit    = 1'b0;
        way    = int'(modelLru[setNum]);
        for (int w = 0; w < 2; w++) begin
            if (modelValid[setNum][w] && modelTag[setNum][w] == a.fields.tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            modelTag[setNum][way]   = a.fields.tag;
            modelValid[setNum][way] = 1'b1;
        end
        // Way just used becomes MRU
        modelLru[setNum] = (way == 0);
    endtask

    // Monitor samples at the falling edge, ahead of the next transfer edge
    always @(negedge clk) begin
        logic        hit;
        logic [31:0] expAddr;
        if (rstN) begin
            // A hit into an empty buffer takes the lookup cycle, then the word is at the head
            if (hitStage == 2) begin
                checkValue("rspValid", rspValid, 1);
                checkValue("busReq", busReq, 0);
                checkValue("rspAddr", rspAddr, hitAddr);
                hitTimingCount++;
                hitStage = 0;
            end else if (hitStage == 1) begin
                checkValue("busReq", busReq, 0);
                checkValue("rspValid", rspValid, 0);
                hitStage = 2;
            end

            if (rspHeld) begin
                if (!rspValid) begin
                    reportError("rspValid dropped before the response was taken");
                end else begin
                    checkValue("rspAddr", rspAddr, heldAddr);
                end
            end
            rspHeld  = rspValid && !rspReady;
            heldAddr = rspAddr;

            if (rspValid && rspReady) begin
                if (rspQueue.size() == 0) begin
                    reportError("response arrived with no outstanding request");
                end else begin
                    expAddr = rspQueue.pop_front();
                    checkValue("rspAddr", rspAddr, expAddr);
                    checkValue("rspData", rspData, expectedWord(expAddr));
                end
            end

            if (busReq && refillQueue.size() == 0) begin
                reportError("busReq raised while no refill was predicted");
            end else if (busReq && busReady) begin
                checkValue("busAddr", busAddr, refillQueue[0] + 32'(beatIdx * 4));
                beatIdx++;
                if (beatIdx == blockWords) begin
                    void'(refillQueue.pop_front());
                    beatIdx = 0;
                end
            end

            if (invalidate) begin
                clearModel();
                invalidateCount++;
            end

            reqFire = reqValid && reqReady;
            if (reqFire) begin
                accessModel(reqAddr, hit);
                rspQueue.push_back(reqAddr);
                if (hit) begin
                    hitCount++;
                    if (!rspValid && hitStage == 0) begin
                        hitStage = 1;
                        hitAddr  = reqAddr;
                    end
                end else begin
                    missCount++;
                    // 16-byte block base
                    refillQueue.push_back(reqAddr & 32'hffff_fff0);
                end
            end
        end
    end

    initial begin
        logic [31:0] blk;
        logic [31:0] wrd;
        logic [31:0] lastBlk;
        logic        slowMode;
        int          waitCycles;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        reqAddr    = '0;
        rspReady   = 1'b0;
        invalidate = 1'b0;
        memStall   = 1'b0;
        lastBlk    = '0;
        slowMode   = 1'b0;
        clearModel();

        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;

        @(negedge clk);
        checkValue("rspValid", rspValid, 0);
        checkValue("busReq", busReq, 0);
        waitCycles = 0;
        while (!reqReady && waitCycles < 4) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!reqReady) begin
            reportError("reqReady did not rise after reset");
        end
        checkValue("rspValid", rspValid, 0);
        checkValue("busReq", busReq, 0);

        while (issued < numRequests || reqValid || rspQueue.size() != 0) begin
            @(posedge clk);
            #1;
            if (reqValid && reqFire) begin
                reqValid = 1'b0;
                issued++;
            end
            if (!reqValid && issued < numRequests && randBits(2) != 0) begin
                // Half the time stay in the last block for locality
                if (randBits(1) == 1) begin
                    blk = lastBlk;
                end else begin
                    blk = randBits(5);
                end
                wrd      = randBits(2);
                lastBlk  = blk;
                reqAddr  = addrBase + {blk[4:0], wrd[1:0], 2'b00};
                reqValid = 1'b1;
            end
            if (randBits(5) == 0) begin
                slowMode = !slowMode;
            end
            rspReady   = slowMode ? (randBits(3) == 0) : (randBits(2) != 0);
            invalidate = (issued < numRequests) && (randBits(7) == 0);
            memStall   = (randBits(2) == 0);
        end

        invalidate = 1'b0;
        rspReady   = 1'b1;
        repeat (4) @(negedge clk);

        // Every request is answered, so nothing may be left or repeated
        checkValue("rspValid", rspValid, 0);
        checkValue("busReq", busReq, 0);
        checkValue("beatCount", beatCount, missCount * blockWords);
        if (refillQueue.size() != 0 || beatIdx != 0) begin
            reportError("a predicted refill never completed");
        end
        if (hitCount == 0 || missCount == 0) begin
            reportError("the run did not see both hits and misses");
        end
        if (invalidateCount == 0) begin
            reportError("no invalidate pulse was driven");
        end
        if (hitTimingCount == 0) begin
            reportError("no hit with an empty buffer was timed");
        end

        $display("icacheTb: %0d requests, %0d hits, %0d misses, %0d invalidates, %0d errors",
                 issued, hitCount, missCount, invalidateCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        reportError("watchdog expired before all requests were answered");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
icachePkg.sv
cacheWays.sv
cacheController.sv
fetchBuffer.sv
instrCache.sv
tbMemory.sv
icacheTb.sv

// File: run.sh
#!/bin/sh
# Build the instruction cache testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module icacheTb -f vlog.f -o icacheSim &&
{ ./obj_dir/icacheSim | tee /dev/stderr | grep -x "Test passed" > /dev/null; } &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
